//--- hw/synth_pkg.sv
package synth_pkg;

	// widths
	localparam int POS_W = 9;	// note position, holds up to the 256 clock note
	localparam int TONE_W = 8;	// tone half-period
	localparam int RATE_W = 5;	// cycles per envelope step
	localparam int VOL_W = 3;	// envelope volume

	localparam int ENV_STEPS = 8;	// steps in a full ramp, 0 to 7 plus the saturating one
	localparam logic [VOL_W-1:0] ENV_MAX = 3'd7;

	// attack / decay code to cycles per step, 0 means no ramp
	localparam logic [RATE_W-1:0] RATE_TABLE [4] = '{
		5'd0,
		5'd2,
		5'd4,
		5'd8
	};

	// length code to note length in note clocks
	localparam logic [POS_W-1:0] LEN_TABLE [8] = '{
		9'd2,
		9'd4,
		9'd8,
		9'd16,
		9'd32,
		9'd64,
		9'd128,
		9'd256
	};

	// envelope phase
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_ATTACK,
		PH_SUSTAIN,
		PH_DECAY
	} note_phase_e;

	// per-cycle command to the volume register
	typedef enum logic [2:0] {
		VC_HOLD,
		VC_CLEAR,	// start of note with a ramp
		VC_FILL,	// start of note, attack bypassed
		VC_UP,
		VC_DOWN
	} vol_cmd_e;

endpackage

//--- hw/note_seq_if.sv
`timescale 1ns/1ps

// phase and timing events between the envelope fsm and the note timer
interface note_seq_if;
	import synth_pkg::*;

	logic start;	// trigger pulse, passed through by the fsm
	note_phase_e phase;	// current envelope phase
	logic attack_bypass;	// level, attack code being latched has rate 0
	logic step_tick;	// divider wrap at the rate of the current window
	logic attack_end;	// pulse at position 8A
	logic decay_begin;	// pulse at position S
	logic note_end;	// pulse at position L

	modport timer (
		input start,
		input phase,
		output attack_bypass,
		output step_tick,
		output attack_end,
		output decay_begin,
		output note_end
	);

	modport fsm (
		output start,
		output phase,
		input attack_bypass,
		input step_tick,
		input attack_end,
		input decay_begin,
		input note_end
	);

endinterface

//--- hw/note_timer.sv
`timescale 1ns/1ps

module note_timer (
	input logic note_clk,
	input logic rst,
	input logic [1:0] attack,
	input logic [1:0] decay,
	input logic [2:0] length,
	note_seq_if.timer seq
);
	import synth_pkg::*;

	logic [RATE_W-1:0] a_in;	// decoded straight from the input codes
	logic [RATE_W-1:0] d_in;
	logic [POS_W-1:0] l_in;
	logic [POS_W-1:0] span_in;	// 8A
	logic [POS_W-1:0] dspan_in;	// 8D
	logic [POS_W-1:0] s_in;
	logic [RATE_W-1:0] a_rate;	// latched at start
	logic [RATE_W-1:0] d_rate;
	logic [POS_W-1:0] l_len;
	logic [POS_W-1:0] s_pos;
	logic dec_on;
	logic [RATE_W-1:0] a_cur;	// latched values, or the fresh ones on a start edge
	logic [RATE_W-1:0] d_cur;
	logic [POS_W-1:0] l_cur;
	logic [POS_W-1:0] s_cur;
	logic [POS_W-1:0] span_cur;
	logic [POS_W-1:0] dbeg_cur;
	logic dec_on_cur;
	logic [POS_W-1:0] pos;	// edges since the trigger
	logic [POS_W-1:0] pos_nxt;
	logic [RATE_W-1:0] div;	// step divider
	logic [RATE_W-1:0] div_nxt;
	logic [RATE_W-1:0] rate_nxt;
	logic run_nxt;	// note still playing after this edge
	logic reload;
	logic tick_q;
	logic atk_end_q;
	logic dec_beg_q;
	logic end_q;

	always_comb
	begin
		a_in = RATE_TABLE[attack];
		d_in = RATE_TABLE[decay];
		l_in = LEN_TABLE[length];
		span_in = POS_W'(a_in * ENV_STEPS);
		dspan_in = POS_W'(d_in * ENV_STEPS);
		// S = max(8A, L-8D) without going negative
		if (l_in > span_in + dspan_in)
			s_in = l_in - dspan_in;
		else
			s_in = span_in;
	end

	always_ff @(posedge note_clk)
	begin
		if (seq.start)
		begin
			a_rate <= a_in;
			d_rate <= d_in;
			l_len <= l_in;
			s_pos <= s_in;
			dec_on <= (d_in != '0) && (s_in < l_in);	// decay only if it fits before the end
		end
	end

	assign a_cur = seq.start ? a_in : a_rate;
	assign d_cur = seq.start ? d_in : d_rate;
	assign l_cur = seq.start ? l_in : l_len;
	assign s_cur = seq.start ? s_in : s_pos;
	assign dec_on_cur = seq.start ? ((d_in != '0) && (s_in < l_in)) : dec_on;
	assign span_cur = POS_W'(a_cur * ENV_STEPS);
	assign dbeg_cur = (s_cur == '0) ? POS_W'(1) : s_cur;	// S of 0 switches phase at p=1, ticks still count from 0

	assign run_nxt = seq.start || (seq.phase != PH_IDLE && !seq.note_end);
	assign pos_nxt = seq.start ? '0 : (seq.phase != PH_IDLE ? pos + 1'b1 : pos);
	assign reload = seq.start || pos_nxt == span_cur || (dec_on_cur && pos_nxt == s_cur);
	assign div_nxt = (reload || seq.step_tick) ? '0 : div + 1'b1;
	assign rate_nxt = (dec_on_cur && pos_nxt >= s_cur) ? d_cur : a_cur;	// decay window uses D

	// events are registered one edge ahead, so they sit high in the cycle before their position
	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			pos <= '0;
			div <= '0;
			tick_q <= 1'b0;
			atk_end_q <= 1'b0;
			dec_beg_q <= 1'b0;
			end_q <= 1'b0;
		end
		else
		begin
			pos <= pos_nxt;
			div <= div_nxt;
			tick_q <= run_nxt && rate_nxt != '0 && div_nxt == rate_nxt - 1'b1;
			atk_end_q <= run_nxt && a_cur != '0 && pos_nxt == span_cur - 1'b1;
			dec_beg_q <= run_nxt && dec_on_cur && pos_nxt == dbeg_cur - 1'b1;
			end_q <= run_nxt && pos_nxt == l_cur - 1'b1;
		end
	end

	assign seq.attack_bypass = (a_in == '0);
	assign seq.step_tick = tick_q;
	assign seq.attack_end = atk_end_q;
	assign seq.decay_begin = dec_beg_q;
	assign seq.note_end = end_q;

	// a note is at least two clocks long, and a retrigger restarts the count
	a_end_single: assert property (@(posedge note_clk) disable iff (rst)
		seq.note_end |=> !seq.note_end);

endmodule

//--- hw/note_fsm.sv
`timescale 1ns/1ps

module note_fsm (
	input logic note_clk,
	input logic rst,
	input logic trigger,
	note_seq_if.fsm seq,
	output synth_pkg::vol_cmd_e vol_cmd,
	output logic note_active
);
	import synth_pkg::*;

	note_phase_e phase;
	note_phase_e phase_nxt;

	assign seq.start = trigger;	// timer latches the codes on the same edge
	assign seq.phase = phase;

	// high on the trigger edge so enable_out rises right after it, low on the last edge
	assign note_active = trigger || (phase != PH_IDLE && !seq.note_end);

	always_comb
	begin
		phase_nxt = phase;
		if (trigger)
			phase_nxt = seq.attack_bypass ? PH_SUSTAIN : PH_ATTACK;	// retrigger restarts too
		else
		begin
			case (phase)
				PH_ATTACK:
				begin
					if (seq.note_end)
						phase_nxt = PH_IDLE;	// attack cut off by a short note
					else if (seq.decay_begin)
						phase_nxt = PH_DECAY;	// S == 8A, no sustain
					else if (seq.attack_end)
						phase_nxt = PH_SUSTAIN;
				end
				PH_SUSTAIN:
				begin
					if (seq.note_end)
						phase_nxt = PH_IDLE;
					else if (seq.decay_begin)
						phase_nxt = PH_DECAY;
				end
				PH_DECAY:
				begin
					if (seq.note_end)
						phase_nxt = PH_IDLE;
				end
				default: phase_nxt = phase;	// idle waits for a trigger
			endcase
		end
	end

	// volume acts on the event edge, so the command comes from the current phase
	always_comb
	begin
		if (trigger)
			vol_cmd = seq.attack_bypass ? VC_FILL : VC_CLEAR;
		else if (seq.step_tick && phase == PH_ATTACK)
			vol_cmd = VC_UP;
		else if (seq.step_tick && phase == PH_DECAY)
			vol_cmd = VC_DOWN;	// also on the last position
		else
			vol_cmd = VC_HOLD;
	end

	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
			phase <= PH_IDLE;
		else
			phase <= phase_nxt;
	end

	// decay_begin from the timer only lands in attack or sustain, so idle never jumps to decay
	a_no_idle_decay: assert property (@(posedge note_clk) disable iff (rst)
		seq.decay_begin |-> phase == PH_ATTACK || phase == PH_SUSTAIN);

endmodule

//--- hw/env_volume.sv
`timescale 1ns/1ps

module env_volume (
	input logic note_clk,
	input logic rst,
	input synth_pkg::vol_cmd_e vol_cmd,
	input logic note_active,
	input logic tone_high,
	output logic [3:0] square_out,
	output logic enable_out
);
	import synth_pkg::*;

	logic [VOL_W-1:0] volume;
	logic ramp_top;	// attack ramp already took its saturating step

	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			volume <= '0;
			enable_out <= 1'b0;
			ramp_top <= 1'b0;
		end
		else
		begin
			enable_out <= note_active;	// high for exactly L periods
			case (vol_cmd)
				VC_CLEAR: volume <= '0;
				VC_FILL: volume <= ENV_MAX;	// zero attack jumps straight to full
				VC_UP: if (volume != ENV_MAX) volume <= volume + 1'b1;
				VC_DOWN: if (volume != '0) volume <= volume - 1'b1;
				default: volume <= volume;
			endcase
			if (vol_cmd == VC_CLEAR || vol_cmd == VC_FILL)
				ramp_top <= 1'b0;
			else if (vol_cmd == VC_UP && volume == ENV_MAX)
				ramp_top <= 1'b1;
		end
	end

	// odd level table 1,3,..,15, silent when the tone is low or the channel is off
	assign square_out = (enable_out && tone_high) ? {volume, 1'b1} : 4'd0;

	// at most 8 attack steps fit, so the saturating step is the last up until a new note
	a_up_after_top: assert property (@(posedge note_clk) disable iff (rst)
		ramp_top |-> vol_cmd != VC_UP);

endmodule

//--- hw/square_osc.sv
`timescale 1ns/1ps

module square_osc (
	input logic note_clk,
	input logic rst,
	input logic trigger,
	input logic [synth_pkg::TONE_W-1:0] tone_period,
	output logic tone_high
);
	import synth_pkg::*;

	logic [TONE_W-1:0] half_cnt;	// edges since the last toggle

	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			half_cnt <= '0;
			tone_high <= 1'b0;
		end
		else if (trigger)
		begin
			half_cnt <= '0;	// every note starts on a high half
			tone_high <= 1'b1;
		end
		else if (half_cnt >= tone_period)	// >= so a shorter new period takes effect at once
		begin
			half_cnt <= '0;
			tone_high <= ~tone_high;	// toggles every tone_period+1 edges
		end
		else
			half_cnt <= half_cnt + 1'b1;	// free-runs while idle as well
	end

endmodule

//--- hw/note_channel.sv
`timescale 1ns/1ps

// one square voice, envelope and length control on note_clk
module note_channel (
	input logic note_clk,
	input logic rst,
	input logic trigger,	// one-cycle note start
	input logic [1:0] attack,
	input logic [1:0] decay,
	input logic [2:0] length,
	input logic [synth_pkg::TONE_W-1:0] tone_period,
	output logic [3:0] square_out,
	output logic enable_out
);
	import synth_pkg::*;

	vol_cmd_e vol_cmd;
	logic note_active;
	logic tone_high;

	note_seq_if seq0 ();	// fsm <-> timer

	note_timer timer0 (
		.note_clk (note_clk),
		.rst (rst),
		.attack (attack),
		.decay (decay),
		.length (length),
		.seq (seq0.timer)
	);

	note_fsm fsm0 (
		.note_clk (note_clk),
		.rst (rst),
		.trigger (trigger),
		.seq (seq0.fsm),
		.vol_cmd (vol_cmd),
		.note_active (note_active)
	);

	env_volume vol0 (
		.note_clk (note_clk),
		.rst (rst),
		.vol_cmd (vol_cmd),
		.note_active (note_active),
		.tone_high (tone_high),
		.square_out (square_out),
		.enable_out (enable_out)
	);

	square_osc osc0 (
		.note_clk (note_clk),
		.rst (rst),
		.trigger (trigger),
		.tone_period (tone_period),
		.tone_high (tone_high)
	);

endmodule

//--- tb/note_channel_tb.sv
`timescale 1ns/1ps

module note_channel_tb;

	localparam int CLK_HALF = 50;	// 100 ns note clock
	localparam int RST_CYCLES = 8;
	localparam int DRIVE_DLY = 5;	// inputs move this long after the rising edge
	localparam int GAP = 2;	// idle cycles between notes
	localparam int IDLE_CYCLES = 10;
	localparam int N_RAND = 40;

	logic note_clk;
	logic rst;
	logic trigger;
	logic [1:0] attack;
	logic [1:0] decay;
	logic [2:0] length;
	logic [7:0] tone_period;
	logic [3:0] square_out;
	logic enable_out;

	int seed;
	int errors;
	int cycles;	// watchdog count
	int limit;
	int total;	// expected length of the whole run in cycles
	logic [1:0] rnd_a [N_RAND];
	logic [1:0] rnd_d [N_RAND];
	logic [2:0] rnd_l [N_RAND];
	logic [7:0] rnd_tp [N_RAND];

	bit m_active;	// cycle model of the channel
	bit m_tone;
	int m_p;
	int m_a;
	int m_d;
	int m_l;
	int m_tp;
	int m_tcnt;	// edges since the last tone toggle
	logic exp_en;
	logic [3:0] exp_sq;

	note_channel dut0 (
		.note_clk (note_clk),
		.rst (rst),
		.trigger (trigger),
		.attack (attack),
		.decay (decay),
		.length (length),
		.tone_period (tone_period),
		.square_out (square_out),
		.enable_out (enable_out)
	);

	initial
	begin
		note_clk = 1'b0;
		forever #CLK_HALF note_clk = ~note_clk;
	end

	// cycles per step, 0 2 4 8
	function automatic int rate_of(input logic [1:0] code);
		if (code == 2'd0)
			return 0;
		return 1 << code;
	endfunction

	function automatic int len_of(input logic [2:0] code);
		return 2 << code;	// 2 up to 256 clocks
	endfunction

	function automatic int note_cycles(input logic [2:0] code);
		return len_of(code) + GAP + 1;	// note, gap and the trigger cycle
	endfunction

	// volume after position p, stepping through the envelope rules edge by edge
	function automatic int exp_volume(input int p, input int a, input int d, input int l);
		int v;
		int top;
		int s;
		int q;
		v = (a == 0) ? 7 : 0;
		top = (8 * a < l) ? 8 * a : l;	// last position an attack step may land on
		s = (8 * a > l - 8 * d) ? 8 * a : l - 8 * d;
		for (q = 1; q <= p && q <= l; q++)
		begin
			if (a > 0 && q % a == 0 && q <= top && v < 7)
				v++;
			if (d > 0 && s < l && q > s && (q - s) % d == 0 && v > 0)
				v--;	// floor at 0
		end
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [3:0] expv,
		input logic [3:0] gotv);
		errors++;
		$display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expv, gotv);
		$display("Verification failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge note_clk);
		#DRIVE_DLY;
	endtask

	// one-cycle trigger with the codes, returns just after the trigger edge
	task automatic start_note(input logic [1:0] a, input logic [1:0] d, input logic [2:0] l,
		input logic [7:0] tp);
		attack = a;
		decay = d;
		length = l;
		tone_period = tp;
		trigger = 1'b1;
		@(posedge note_clk);
		#DRIVE_DLY;
		trigger = 1'b0;
	endtask

	task automatic wait_note_end();
		wait (enable_out == 1'b0);	// watchdog catches a note that never ends
		#DRIVE_DLY;
		idle_cycles(GAP);
	endtask

	task automatic play_note(input logic [1:0] a, input logic [1:0] d, input logic [2:0] l,
		input logic [7:0] tp);
		start_note(a, d, l, tp);
		wait_note_end();
	endtask

	// model steps on the rising edge, DUT outputs compared half a period later
	always
	begin
		@(posedge note_clk);
		if (rst)
		begin
			m_active = 1'b0;
			m_p = 0;
			m_tone = 1'b0;
			m_tcnt = 0;
			m_tp = 0;
		end
		else if (trigger)
		begin
			m_a = rate_of(attack);	// retrigger lands here as well
			m_d = rate_of(decay);
			m_l = len_of(length);
			m_tp = int'(tone_period);
			m_p = 0;
			m_active = 1'b1;
			m_tone = 1'b1;	// note starts on a high half
			m_tcnt = 0;
		end
		else
		begin
			if (m_active)
			begin
				m_p++;
				if (m_p == m_l)
					m_active = 1'b0;	// enable drops after edge k+L
			end
			m_tcnt++;
			if (m_tcnt == m_tp + 1)
			begin
				m_tone = !m_tone;
				m_tcnt = 0;
			end
		end
		exp_en = m_active;
		exp_sq = (m_active && m_tone) ? 4'(2 * exp_volume(m_p, m_a, m_d, m_l) + 1) : 4'd0;
		@(negedge note_clk);
		assert (enable_out === exp_en) else report_mismatch("enable_out", 4'(exp_en), 4'(enable_out));
		assert (square_out === exp_sq) else report_mismatch("square_out", exp_sq, square_out);
	end

	always @(posedge note_clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout after %0d cycles, a note never ended and the run hung", cycles);
			$display("Verification failed");
			$fatal(1, "watchdog limit reached");
		end
	end

	initial
	begin
		int i;
		int r;
		seed = 20173;
		errors = 0;
		cycles = 0;
		rst = 1'b1;
		trigger = 1'b0;
		attack = 2'd0;
		decay = 2'd0;
		length = 3'd0;
		tone_period = 8'd0;
		total = IDLE_CYCLES;
		for (i = 0; i < 8; i++)
			total += note_cycles(3'(i));
		total += note_cycles(3'd7) + note_cycles(3'd5) + note_cycles(3'd1);
		total += note_cycles(3'd6) + note_cycles(3'd5);	// both notes of the retrigger
		for (i = 0; i < N_RAND; i++)
		begin
			r = $random(seed);
			rnd_a[i] = r[1:0];
			rnd_d[i] = r[3:2];
			rnd_l[i] = r[6:4];
			rnd_tp[i] = {2'b00, r[13:8]};
			total += note_cycles(rnd_l[i]);
		end
		limit = total + total / 5 + RST_CYCLES;
		repeat (RST_CYCLES) @(posedge note_clk);
		#DRIVE_DLY rst = 1'b0;
		idle_cycles(IDLE_CYCLES);	// silent without a trigger
		for (i = 0; i < 8; i++)
			play_note(2'd0, 2'd0, 3'(i), 8'(i));	// full volume, every length
		play_note(2'd3, 2'd0, 3'd7, 8'd5);	// slow attack, then hold
		play_note(2'd1, 2'd2, 3'd5, 8'd2);	// decay from S = 32
		play_note(2'd3, 2'd2, 3'd1, 8'd0);	// attack cut short, no decay
		start_note(2'd2, 2'd1, 3'd6, 8'd4);
		idle_cycles(20);	// retrigger in the middle of the attack
		play_note(2'd1, 2'd1, 3'd5, 8'd7);
		for (i = 0; i < N_RAND; i++)
			play_note(rnd_a[i], rnd_d[i], rnd_l[i], rnd_tp[i]);
		idle_cycles(4);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- vlog.f
hw/synth_pkg.sv
hw/note_seq_if.sv
hw/note_timer.sv
hw/note_fsm.sv
hw/env_volume.sv
hw/square_osc.sv
hw/note_channel.sv
tb/note_channel_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := note_channel_tb
DUT_TOP := note_channel
FILELIST := vlog.f
FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
